//--- cross_add_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cross_add_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               pp_valid,
    input  mul_types_pkg::pp_t pp_data,
    output logic               cb_valid,
    output mul_types_pkg::comb_t cb_data
);

    mul_types_pkg::comb_t cb_next;

    assign cb_next.op2    = {1'b0, pp_data.p_hl} + {1'b0, pp_data.p_lh};
    assign cb_next.op1    = {pp_data.p_hh,
                             pp_data.p_ll[mul_cfg_pkg::ll_w-1:mul_cfg_pkg::lo_w]};
    assign cb_next.ll_low = pp_data.p_ll[mul_cfg_pkg::lo_w-1:0];  // Final result bits.

    always_ff @(posedge clk) begin
        if (rst) begin
            cb_valid <= 1'b0;
        end else begin
            cb_valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            cb_data <= cb_next;
        end
    end

endmodule

`default_nettype wire

//--- final_add_stage.sv
`timescale 1ns/1ps
`default_nettype none

module final_add_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cb_valid,
    input  mul_types_pkg::comb_t             cb_data,
    output logic                             out_valid,
    output logic [mul_cfg_pkg::prod_w-1:0]   product
);

    logic [mul_cfg_pkg::op1_w-1:0] sum;

    // Carry out of bit 18 lies above 32 bits.
    assign sum = cb_data.op1
               + {{(mul_cfg_pkg::op1_w - mul_cfg_pkg::op2_w){1'b0}}, cb_data.op2};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= cb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cb_valid) begin
            product <= {sum, cb_data.ll_low};
        end
    end

endmodule

`default_nettype wire

//--- flist.f
mul_cfg_pkg.sv
mul_types_pkg.sv
nr_mul.sv
rr13_mul.sv
pp_stage.sv
cross_add_stage.sv
final_add_stage.sv
mul16_pipe.sv
mul16_checker.sv
mul16_tb.sv

//--- mul16_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mul16_checker (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  mul_types_pkg::operand_t        in_ops,
    input  logic                           out_valid,
    input  logic [mul_cfg_pkg::prod_w-1:0] product
);

    logic [mul_cfg_pkg::prod_w-1:0] a_ext;
    logic [mul_cfg_pkg::prod_w-1:0] b_ext;
    int                             assert_errors = 0;

    assign a_ext = in_ops.a;   // Zero extended to product width.
    assign b_ext = in_ops.b;

    // Needs three clean cycles before the strobe history is valid.
    valid_latency: assert property (@(posedge clk)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3))
            |-> out_valid == $past(in_valid, mul_cfg_pkg::pipe_lat))
    else begin
        $error("Mismatch out_valid: expected %h, actual %h",
               $past(in_valid, mul_cfg_pkg::pipe_lat), $sampled(out_valid));
        assert_errors++;
    end

    product_exact: assert property (@(posedge clk)
        out_valid |-> product == $past(a_ext, mul_cfg_pkg::pipe_lat)
                               * $past(b_ext, mul_cfg_pkg::pipe_lat))
    else begin
        $error("Mismatch product: expected %h, actual %h",
               $past(a_ext, mul_cfg_pkg::pipe_lat) * $past(b_ext, mul_cfg_pkg::pipe_lat),
               $sampled(product));
        assert_errors++;
    end

    reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        $error("Mismatch out_valid: expected %h, actual %h", 1'b0, $sampled(out_valid));
        assert_errors++;
    end

endmodule

bind mul16_pipe mul16_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ops    (in_ops),
    .out_valid (out_valid),
    .product   (product)
);

`default_nettype wire

//--- mul16_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mul16_pipe (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  mul_types_pkg::operand_t        in_ops,
    output logic                           out_valid,
    output logic [mul_cfg_pkg::prod_w-1:0] product
);

    logic                 pp_valid;
    mul_types_pkg::pp_t   pp_data;
    logic                 cb_valid;
    mul_types_pkg::comb_t cb_data;

    // Partial products.
    pp_stage u_pp_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ops   (in_ops),
        .pp_valid (pp_valid),
        .pp_data  (pp_data)
    );

    // Cross-term addition.
    cross_add_stage u_cross_add_stage (
        .clk      (clk),
        .rst      (rst),
        .pp_valid (pp_valid),
        .pp_data  (pp_data),
        .cb_valid (cb_valid),
        .cb_data  (cb_data)
    );

    // Final addition.
    final_add_stage u_final_add_stage (
        .clk       (clk),
        .rst       (rst),
        .cb_valid  (cb_valid),
        .cb_data   (cb_data),
        .out_valid (out_valid),
        .product   (product)
    );

endmodule

`default_nettype wire

//--- mul16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mul16_tb;

    logic                           clk;
    logic                           rst;
    logic                           in_valid;
    mul_types_pkg::operand_t        in_ops;
    logic                           out_valid;
    logic [mul_cfg_pkg::prod_w-1:0] product;

    logic [mul_cfg_pkg::prod_w-1:0] exp_q[$];
    integer                         seed;
    int                             mismatch_errors = 0;
    int                             unexpected_errors = 0;
    int                             timeout_errors = 0;
    int                             assert_errors = 0;
    int                             total_errors = 0;

    mul16_pipe UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ops    (in_ops),
        .out_valid (out_valid),
        .product   (product)
    );

    always #50 clk = ~clk;

    function automatic logic [mul_cfg_pkg::prod_w-1:0] exact_product(
        input logic [mul_cfg_pkg::op_w-1:0] a,
        input logic [mul_cfg_pkg::op_w-1:0] b
    );
        logic [mul_cfg_pkg::prod_w-1:0] a_ext;
        logic [mul_cfg_pkg::prod_w-1:0] b_ext;
        a_ext = a;
        b_ext = b;
        return a_ext * b_ext;
    endfunction

    function logic [mul_cfg_pkg::op_w-1:0] next_random();
        next_random = $random(seed);
    endfunction

    // Pairs the first stage captures; reset drops all in flight.
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
        end else if (in_valid) begin
            exp_q.push_back(exact_product(in_ops.a, in_ops.b));
        end
    end

    always @(negedge clk) begin : monitor
        logic [mul_cfg_pkg::prod_w-1:0] expected;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output: out_valid high with no pair in flight at %0t",
                         $time);
                unexpected_errors++;
            end else begin
                expected = exp_q.pop_front();
                if (product !== expected) begin
                    $display("Mismatch product: expected %h, actual %h", expected, product);
                    mismatch_errors++;
                end
            end
        end
    end

    task automatic drive_pair(
        input logic [mul_cfg_pkg::op_w-1:0] a,
        input logic [mul_cfg_pkg::op_w-1:0] b
    );
        @(negedge clk);
        in_valid = 1'b1;
        in_ops.a = a;
        in_ops.b = b;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        idle(1);
        do begin
            @(posedge clk);
            waited++;
        end while (exp_q.size() != 0 && waited < limit);
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), limit);
            timeout_errors++;
        end
    endtask

    initial begin
        logic [mul_cfg_pkg::op_w-1:0] a;
        logic [mul_cfg_pkg::op_w-1:0] b;
        int                           gap;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_ops = '0;
        seed = 89324;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        drive_pair(16'h0000, 16'h0000);
        drive_pair(16'h0000, 16'hffff);
        drive_pair(16'hffff, 16'h0000);
        drive_pair(16'h0001, 16'h5a3c);
        drive_pair(16'hc3a5, 16'h0001);
        drive_pair(16'hffff, 16'hffff);
        for (int i = 0; i < 16; i++) begin    // Both sides of bit 13.
            drive_pair(16'h1 << i, 16'h1 << (15 - i));
            drive_pair(16'h1 << i, 16'h1 << 13);
            drive_pair(16'h1 << 12, 16'h1 << i);
        end
        wait_drain(20);

        drive_pair(16'he000, 16'he000);
        drive_pair(16'h1fff, 16'h1fff);
        drive_pair(16'he000, 16'h1fff);
        drive_pair(16'h1fff, 16'he000);
        for (int i = 0; i < 24; i++) begin
            a = next_random();
            b = next_random();
            drive_pair(a & 16'he000, b & 16'he000);
            drive_pair(a & 16'h1fff, b & 16'h1fff);
            drive_pair(a & 16'he000, b & 16'h1fff);
            drive_pair(a, b);
        end
        wait_drain(20);

        for (int i = 0; i < 200; i++) begin
            drive_pair(next_random(), next_random());
        end
        wait_drain(20);

        for (int i = 0; i < 100; i++) begin
            drive_pair(next_random(), next_random());
            gap = next_random() & 3;
            idle(gap);
        end
        wait_drain(20);

        // Reset with items still in the pipeline.
        for (int i = 0; i < 3; i++) begin
            drive_pair(next_random(), next_random());
        end
        @(negedge clk);
        in_valid = 1'b0;
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        idle(6);
        for (int i = 0; i < 20; i++) begin
            drive_pair(next_random(), next_random());
        end
        wait_drain(20);
        idle(5);

        assert_errors = UUT.u_checker.assert_errors;
        total_errors = mismatch_errors + unexpected_errors + timeout_errors + assert_errors;
        $display("Error counts: mismatch %0d, unexpected %0d, timeout %0d, assertion %0d",
                 mismatch_errors, unexpected_errors, timeout_errors, assert_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mul_cfg_pkg.sv
`default_nettype none

package mul_cfg_pkg;

    // Operand and product widths.
    localparam int op_w   = 16;
    localparam int prod_w = 2 * op_w;

    // Top-level split of each operand at bit 13.
    localparam int hi_w = 3;
    localparam int lo_w = op_w - hi_w;

    // Second split inside the 13x13 product.
    localparam int sub_hi_w = 11;
    localparam int sub_lo_w = lo_w - sub_hi_w;

    // Partial product widths at the top level.
    localparam int hh_w    = 2 * hi_w;
    localparam int cross_w = hi_w + lo_w;
    localparam int ll_w    = 2 * lo_w;

    // Combine operands for the final addition.
    localparam int op1_w = hh_w + lo_w;
    localparam int op2_w = cross_w + 1;       // Cross sum carry.

    // Partial product widths inside the 13x13 block.
    localparam int sub_hh_w    = 2 * sub_hi_w;
    localparam int sub_cross_w = sub_hi_w + sub_lo_w;
    localparam int sub_ll_w    = 2 * sub_lo_w;
    localparam int sub_op1_w   = sub_hh_w + sub_lo_w;

    // Input to output latency in cycles.
    localparam int pipe_lat = 3;

endpackage

`default_nettype wire

//--- mul_types_pkg.sv
`default_nettype none

package mul_types_pkg;

    // Operand pair.
    typedef struct packed {
        logic [mul_cfg_pkg::op_w-1:0] a;
        logic [mul_cfg_pkg::op_w-1:0] b;
    } operand_t;

    // Partial products after the first stage.
    typedef struct packed {
        logic [mul_cfg_pkg::hh_w-1:0]    p_hh;   // High a times high b.
        logic [mul_cfg_pkg::cross_w-1:0] p_hl;   // High a times low b.
        logic [mul_cfg_pkg::cross_w-1:0] p_lh;   // Low a times high b.
        logic [mul_cfg_pkg::ll_w-1:0]    p_ll;   // Low a times low b.
    } pp_t;

    // Operands for the final addition.
    typedef struct packed {
        logic [mul_cfg_pkg::op1_w-1:0] op1;      // p_hh over upper half of p_ll.
        logic [mul_cfg_pkg::op2_w-1:0] op2;      // Cross sum.
        logic [mul_cfg_pkg::lo_w-1:0]  ll_low;   // Passes to the result as is.
    } comb_t;

endpackage

`default_nettype wire

//--- nr_mul.sv
`timescale 1ns/1ps
`default_nettype none

module nr_mul #(
    parameter int a_w = 8,
    parameter int b_w = 8
) (
    input  logic [a_w-1:0]     a,
    input  logic [b_w-1:0]     b,
    output logic [a_w+b_w-1:0] p
);

    logic [a_w+b_w-1:0] a_ext;
    logic [a_w+b_w-1:0] acc;

    assign a_ext = {{b_w{1'b0}}, a};     // Room for every shift.

    // One shifted copy of a per set bit of b.
    always_comb begin
        acc = '0;
        for (int i = 0; i < b_w; i++) begin
            if (b[i]) begin
                acc = acc + (a_ext << i);
            end
        end
    end

    assign p = acc;

endmodule

`default_nettype wire

//--- pp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pp_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  mul_types_pkg::operand_t in_ops,
    output logic                    pp_valid,
    output mul_types_pkg::pp_t      pp_data
);

    logic [mul_cfg_pkg::hi_w-1:0] a_h;
    logic [mul_cfg_pkg::hi_w-1:0] b_h;
    logic [mul_cfg_pkg::lo_w-1:0] a_l;
    logic [mul_cfg_pkg::lo_w-1:0] b_l;
    mul_types_pkg::pp_t           pp_next;

    // Split both operands at bit 13.
    assign a_h = in_ops.a[mul_cfg_pkg::op_w-1:mul_cfg_pkg::lo_w];
    assign b_h = in_ops.b[mul_cfg_pkg::op_w-1:mul_cfg_pkg::lo_w];
    assign a_l = in_ops.a[mul_cfg_pkg::lo_w-1:0];
    assign b_l = in_ops.b[mul_cfg_pkg::lo_w-1:0];

    nr_mul #(.a_w(mul_cfg_pkg::hi_w), .b_w(mul_cfg_pkg::hi_w))
        u_hh (.a(a_h), .b(b_h), .p(pp_next.p_hh));
    nr_mul #(.a_w(mul_cfg_pkg::hi_w), .b_w(mul_cfg_pkg::lo_w))
        u_hl (.a(a_h), .b(b_l), .p(pp_next.p_hl));
    nr_mul #(.a_w(mul_cfg_pkg::lo_w), .b_w(mul_cfg_pkg::hi_w))
        u_lh (.a(a_l), .b(b_h), .p(pp_next.p_lh));

    rr13_mul u_ll (
        .a (a_l),
        .b (b_l),
        .p (pp_next.p_ll)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= in_valid;
        end
    end

    // Holds the last accepted pair.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pp_data <= pp_next;
        end
    end

endmodule

`default_nettype wire

//--- rr13_mul.sv
`timescale 1ns/1ps
`default_nettype none

module rr13_mul (
    input  logic [mul_cfg_pkg::lo_w-1:0] a,
    input  logic [mul_cfg_pkg::lo_w-1:0] b,
    output logic [mul_cfg_pkg::ll_w-1:0] p
);

    logic [mul_cfg_pkg::sub_hi_w-1:0]    a_h;
    logic [mul_cfg_pkg::sub_hi_w-1:0]    b_h;
    logic [mul_cfg_pkg::sub_lo_w-1:0]    a_l;
    logic [mul_cfg_pkg::sub_lo_w-1:0]    b_l;
    logic [mul_cfg_pkg::sub_hh_w-1:0]    p_hh;
    logic [mul_cfg_pkg::sub_cross_w-1:0] p_hl;
    logic [mul_cfg_pkg::sub_cross_w-1:0] p_lh;
    logic [mul_cfg_pkg::sub_ll_w-1:0]    p_ll;
    logic [mul_cfg_pkg::sub_cross_w:0]   cross_sum;
    logic [mul_cfg_pkg::sub_op1_w-1:0]   op1;
    logic [mul_cfg_pkg::sub_op1_w-1:0]   sum;

    assign a_h = a[mul_cfg_pkg::lo_w-1:mul_cfg_pkg::sub_lo_w];
    assign b_h = b[mul_cfg_pkg::lo_w-1:mul_cfg_pkg::sub_lo_w];
    assign a_l = a[mul_cfg_pkg::sub_lo_w-1:0];
    assign b_l = b[mul_cfg_pkg::sub_lo_w-1:0];

    nr_mul #(.a_w(mul_cfg_pkg::sub_hi_w), .b_w(mul_cfg_pkg::sub_hi_w))
        u_hh (.a(a_h), .b(b_h), .p(p_hh));
    nr_mul #(.a_w(mul_cfg_pkg::sub_hi_w), .b_w(mul_cfg_pkg::sub_lo_w))
        u_hl (.a(a_h), .b(b_l), .p(p_hl));
    nr_mul #(.a_w(mul_cfg_pkg::sub_lo_w), .b_w(mul_cfg_pkg::sub_hi_w))
        u_lh (.a(a_l), .b(b_h), .p(p_lh));
    nr_mul #(.a_w(mul_cfg_pkg::sub_lo_w), .b_w(mul_cfg_pkg::sub_lo_w))
        u_ll (.a(a_l), .b(b_l), .p(p_ll));

    assign cross_sum = {1'b0, p_hl} + {1'b0, p_lh};
    assign op1       = {p_hh, p_ll[mul_cfg_pkg::sub_ll_w-1:mul_cfg_pkg::sub_lo_w]};

    // Exact product never overflows the op1 width.
    assign sum = op1 + {{(mul_cfg_pkg::sub_op1_w - mul_cfg_pkg::sub_cross_w - 1){1'b0}},
                        cross_sum};

    assign p = {sum, p_ll[mul_cfg_pkg::sub_lo_w-1:0]};

endmodule

`default_nettype wire
